// ==== vlog.f ====
+incdir+common
common/pipe_pkg.sv
common/mem_pkg.sv
rtl/ex_mem_regs.sv
mem_stage/mem_stage_ctrl.sv
mem_stage/lsu_align.sv
mem_stage/data_ram.sv
rtl/csr_file.sv
rtl/mem_wb_regs.sv
rtl/mem_subsystem_top.sv
tests/mem_assertions.sv
tests/mem_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the memory-stage testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing --assert -f vlog.f --top-module mem_tb \
    -Mdir "$BUILD_DIR" -o mem_tb_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"./$BUILD_DIR/mem_tb_sim" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "NO ERRORS" "$LOG"; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed, see $LOG"
exit 1

// ==== tests/mem_tb.sv ====
`timescale 1ns/10ps
`include "pipeline_consts.svh"

module mem_tb
    import pipe_pkg::*;
();

    localparam int          NUM_INSTR      = 400;
    localparam int          TIMEOUT_CYCLES = NUM_INSTR * (1 + `MEM_WAIT_CYCLES) + 50;
    localparam logic [31:0] SEED           = 32'h4434;

    logic      clk = 1'b0;
    logic      rst_n;
    word_t     pc4_in;
    word_t     b_in;
    word_t     c_in;
    word_t     z_in;
    funct3_t   funct3_in;
    reg_addr_t rd_in;
    csr_addr_t csr_addr_in;
    ir_type_t  ir_type_in;
    logic      wr_reg_n_in;
    logic      wr_csr_n_in;
    logic      flush_in;
    logic      stall;
    reg_addr_t wb_rd;
    word_t     wb_data;
    logic      wb_we;

    // byte-wide copy of the data ram indexed by z[7:0]
    logic [7:0] model_mem [4*`DMEM_WORDS] = '{default: '0};
    word_t      model_csr [4] = '{default: '0};
    reg_addr_t  exp_rd_q [$];
    word_t      exp_data_q [$];
    int         exp_cyc_q [$];
    int         cycle_count = 0;

    mem_subsystem_top dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .pc4_in      (pc4_in),
        .b_in        (b_in),
        .c_in        (c_in),
        .z_in        (z_in),
        .funct3_in   (funct3_in),
        .rd_in       (rd_in),
        .csr_addr_in (csr_addr_in),
        .ir_type_in  (ir_type_in),
        .wr_reg_n_in (wr_reg_n_in),
        .wr_csr_n_in (wr_csr_n_in),
        .flush_in    (flush_in),
        .stall       (stall),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .wb_we       (wb_we)
    );

    always #50 clk = ~clk;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp)
            abort_run($sformatf("FAIL %0d ns: %s, got %h expected %h", $time, what, got, exp));
    endtask

    function automatic int csr_index(input csr_addr_t addr);
        case (addr)
            `CSR_MSCRATCH: return 0;
            `CSR_MTVEC:    return 1;
            `CSR_MEPC:     return 2;
            `CSR_MCAUSE:   return 3;
            default:       return -1;
        endcase
    endfunction

    // halfword and word loads ignore the low address bits
    function automatic word_t model_load(input logic [7:0] addr, input funct3_t f3);
        logic [7:0]  a;
        logic [15:0] half;
        a = addr;
        case (f3)
            3'b000:  return {{24{model_mem[a][7]}}, model_mem[a]};
            3'b100:  return {24'h0, model_mem[a]};
            3'b001, 3'b101: begin
                a[0] = 1'b0;
                half = {model_mem[a + 8'd1], model_mem[a]};
                return (f3 == 3'b001) ? {{16{half[15]}}, half} : {16'h0, half};
            end
            default: begin
                a[1:0] = 2'b00;
                return {model_mem[a + 8'd3], model_mem[a + 8'd2],
                        model_mem[a + 8'd1], model_mem[a]};
            end
        endcase
    endfunction

    task automatic model_store(input logic [7:0] addr, input funct3_t f3, input word_t data);
        logic [7:0] a;
        a = addr;
        case (f3)
            3'b000: model_mem[a] = data[7:0];
            3'b001: begin
                a[0] = 1'b0;
                model_mem[a] = data[7:0];
                model_mem[a + 8'd1] = data[15:8];
            end
            default: begin
                a[1:0] = 2'b00;
                for (int i = 0; i < 4; i++)
                    model_mem[a + 8'(i)] = data[8*i +: 8];
            end
        endcase
    endtask

    task automatic set_idle();
        pc4_in      = `DEFAULT_PC4;
        b_in        = `DEFAULT_B;
        c_in        = `DEFAULT_C;
        z_in        = `DEFAULT_Z;
        funct3_in   = `DEFAULT_FUNCT3;
        rd_in       = `DEFAULT_REG;
        csr_addr_in = `DEFAULT_CSR_ADDR;
        ir_type_in  = IR_NOP;
        wr_reg_n_in = `DEFAULT_WR_N;
        wr_csr_n_in = `DEFAULT_WR_N;
        flush_in    = `DEFAULT_FLUSH;
    endtask

    // first four instructions read every csr straight after reset
    task automatic gen_instr(input int idx);
        int pick;
        pick        = int'($urandom % 100);
        pc4_in      = $urandom;
        b_in        = $urandom;
        c_in        = $urandom;
        z_in        = $urandom;
        funct3_in   = funct3_t'($urandom % 8);
        rd_in       = reg_addr_t'($urandom % 32);
        csr_addr_in = csr_addr_t'($urandom % 4096);
        wr_reg_n_in = ($urandom % 4) == 0;
        wr_csr_n_in = ($urandom % 4) == 0;
        flush_in    = ($urandom % 10) == 0;
        if (pick < 20)
            ir_type_in = IR_ALU;
        else if (pick < 42)
            ir_type_in = IR_LOAD;
        else if (pick < 64)
            ir_type_in = IR_STORE;
        else if (pick < 80)
            ir_type_in = IR_CSR;
        else if (pick < 92)
            ir_type_in = IR_JUMP;
        else
            ir_type_in = IR_NOP;
        case ($urandom % 5)
            0: csr_addr_in = `CSR_MSCRATCH;
            1: csr_addr_in = `CSR_MTVEC;
            2: csr_addr_in = `CSR_MEPC;
            3: csr_addr_in = `CSR_MCAUSE;
            default: ;
        endcase
        if (idx < 4) begin
            ir_type_in  = IR_CSR;
            flush_in    = 1'b0;
            wr_reg_n_in = 1'b0;
            wr_csr_n_in = 1'b1;
            rd_in       = reg_addr_t'(idx + 1);
            csr_addr_in = (idx == 0) ? `CSR_MSCRATCH : (idx == 1) ? `CSR_MTVEC :
                          (idx == 2) ? `CSR_MEPC : `CSR_MCAUSE;
        end
        if (ir_type_in == IR_LOAD || ir_type_in == IR_STORE)
            z_in = (($urandom % 4) == 0) ? ($urandom % 256) : ($urandom % 64);
        if (ir_type_in == IR_LOAD) begin
            pick = int'($urandom % 5);
            funct3_in = (pick < 3) ? funct3_t'(pick) : funct3_t'(pick + 1);
        end
        if (ir_type_in == IR_STORE)
            funct3_in = funct3_t'($urandom % 3);
    endtask

    task automatic model_instr(output logic expect_wb);
        word_t wb_val;
        logic  wb_en;
        int    ci;
        wb_val = z_in;
        wb_en  = !flush_in && !wr_reg_n_in && (rd_in != '0);
        ci     = csr_index(csr_addr_in);
        case (ir_type_in)
            IR_LOAD: wb_val = model_load(z_in[7:0], funct3_in);
            IR_STORE: begin
                wb_en = 1'b0;
                if (!flush_in)
                    model_store(z_in[7:0], funct3_in, b_in);
            end
            IR_CSR: begin
                wb_val = (ci < 0) ? '0 : model_csr[ci];
                if (!flush_in && !wr_csr_n_in && ci >= 0)
                    model_csr[ci] = c_in;
            end
            IR_JUMP: wb_val = pc4_in;
            IR_NOP:  wb_en = 1'b0;
            default: ;
        endcase
        if (wb_en) begin
            exp_rd_q.push_back(rd_in);
            exp_data_q.push_back(wb_val);
        end
        expect_wb = wb_en;
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES)
            abort_run($sformatf("run did not complete within %0d cycles", TIMEOUT_CYCLES));
    end

    always @(negedge clk) begin : wb_monitor
        reg_addr_t exp_rd;
        word_t     exp_data;
        int        exp_cyc;
        if (rst_n && wb_we) begin
            if (exp_data_q.size() == 0 || exp_cyc_q.size() == 0) begin
                abort_run($sformatf("unexpected writeback to x%0d at %0d ns", wb_rd, $time));
            end else begin
                exp_rd   = exp_rd_q.pop_front();
                exp_data = exp_data_q.pop_front();
                exp_cyc  = exp_cyc_q.pop_front();
                check_value(32'(cycle_count), 32'(exp_cyc), "writeback cycle");
                check_value(32'(wb_rd), 32'(exp_rd), "writeback register");
                check_value(wb_data, exp_data, "writeback data");
            end
        end
    end

    initial begin
        int   stall_cycles;
        logic is_mem;
        logic expect_wb;
        void'($urandom(SEED));
        rst_n = 1'b0;
        set_idle();
        repeat (10) @(posedge clk);
        #5;
        rst_n = 1'b1;
        check_value(32'(stall), 32'd0, "stall after reset");
        check_value(32'(wb_we), 32'd0, "wb_we after reset");
        for (int i = 0; i < NUM_INSTR; i++) begin
            gen_instr(i);
            model_instr(expect_wb);
            is_mem = (ir_type_in == IR_LOAD) || (ir_type_in == IR_STORE);
            stall_cycles = 0;
            @(posedge clk);
            #5;
            while (stall) begin
                stall_cycles++;
                @(posedge clk);
                #5;
            end
            check_value(32'(stall_cycles), is_mem ? `MEM_WAIT_CYCLES : 0, "stall length");
            // writeback lands at the edge that ends the last cycle in ex_mem
            if (expect_wb)
                exp_cyc_q.push_back(cycle_count + 1);
        end
        set_idle();
        repeat (4) @(posedge clk);
        #5;
        if (exp_data_q.size() != 0) begin
            abort_run($sformatf("%0d expected writebacks never arrived", exp_data_q.size()));
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

// ==== tests/mem_assertions.sv ====
`timescale 1ns/10ps
`include "pipeline_consts.svh"

module mem_assertions (
    input logic clk,
    input logic rst_n,
    input logic flush,
    input logic interlock,
    input logic ram_we,
    input logic csr_we,
    input logic wb_we_next
);

    // a finished access held interlock for exactly the wait time
    a_wait_len: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(interlock) |-> $past(interlock, `MEM_WAIT_CYCLES) &&
                             !$past(interlock, `MEM_WAIT_CYCLES + 1))
        else $error("interlock length differs from the memory wait time");

    // the store lands in the cycle right after the wait
    a_we_vs_lock: assert property (@(posedge clk) disable iff (!rst_n)
        ram_we |-> !interlock && $past(interlock))
        else $error("ram write outside the cycle after the wait");

    // a flushed access stays quiet through its held cycles
    a_flush_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        (flush || $past(flush && interlock)) |-> !ram_we && !csr_we)
        else $error("write enable raised for a flushed instruction");

    a_reset_idle: assert property (@(posedge clk)
        $rose(rst_n) |-> !interlock && !ram_we && !csr_we && !wb_we_next)
        else $error("enable active right after reset");

endmodule

bind mem_stage_ctrl mem_assertions u_ctrl_assert (
    .clk        (clk),
    .rst_n      (rst_n),
    .flush      (flush),
    .interlock  (interlock),
    .ram_we     (ram_we),
    .csr_we     (csr_we),
    .wb_we_next (wb_we_next)
);

// ==== rtl/mem_subsystem_top.sv ====
`timescale 1ns/10ps

module mem_subsystem_top
    import pipe_pkg::*;
    import mem_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  word_t     pc4_in,
    input  word_t     b_in,
    input  word_t     c_in,
    input  word_t     z_in,
    input  funct3_t   funct3_in,
    input  reg_addr_t rd_in,
    input  csr_addr_t csr_addr_in,
    input  ir_type_t  ir_type_in,
    input  logic      wr_reg_n_in,
    input  logic      wr_csr_n_in,
    input  logic      flush_in,
    output logic      stall,
    output reg_addr_t wb_rd,
    output word_t     wb_data,
    output logic      wb_we
);

    word_t     pc4;
    word_t     b;
    word_t     c;
    word_t     z;
    funct3_t   funct3;
    reg_addr_t rd;
    csr_addr_t csr_addr;
    ir_type_t  ir_type;
    logic      wr_reg_n;
    logic      wr_csr_n;
    logic      flush;
    logic      interlock;
    logic      ram_we;
    logic      csr_we;
    logic      wb_we_next;
    byte_en_t  byte_en;
    word_t     ram_wdata;
    word_t     ram_rdata;
    word_t     load_data;
    word_t     csr_old;

    assign stall = interlock;

    ex_mem_regs u_ex_mem (
        .clk          (clk),
        .rst_n        (rst_n),
        .interlock    (interlock),
        .pc4_in       (pc4_in),
        .b_in         (b_in),
        .c_in         (c_in),
        .z_in         (z_in),
        .funct3_in    (funct3_in),
        .rd_in        (rd_in),
        .csr_addr_in  (csr_addr_in),
        .ir_type_in   (ir_type_in),
        .wr_reg_n_in  (wr_reg_n_in),
        .wr_csr_n_in  (wr_csr_n_in),
        .flush_in     (flush_in),
        .pc4_out      (pc4),
        .b_out        (b),
        .c_out        (c),
        .z_out        (z),
        .funct3_out   (funct3),
        .rd_out       (rd),
        .csr_addr_out (csr_addr),
        .ir_type_out  (ir_type),
        .wr_reg_n_out (wr_reg_n),
        .wr_csr_n_out (wr_csr_n),
        .flush_out    (flush)
    );

    mem_stage_ctrl u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .ir_type    (ir_type),
        .flush      (flush),
        .wr_reg_n   (wr_reg_n),
        .wr_csr_n   (wr_csr_n),
        .rd         (rd),
        .interlock  (interlock),
        .ram_we     (ram_we),
        .csr_we     (csr_we),
        .wb_we_next (wb_we_next)
    );

    lsu_align u_lsu (
        .addr_lo    (z[1:0]),
        .funct3     (funct3),
        .store_data (b),
        .ram_rdata  (ram_rdata),
        .byte_en    (byte_en),
        .ram_wdata  (ram_wdata),
        .load_data  (load_data)
    );

    data_ram u_ram (
        .clk     (clk),
        .addr    (z[7:2]),
        .we      (ram_we),
        .byte_en (byte_en),
        .wdata   (ram_wdata),
        .rdata   (ram_rdata)
    );

    csr_file u_csr (
        .clk      (clk),
        .rst_n    (rst_n),
        .csr_addr (csr_addr),
        .wdata    (c),
        .we       (csr_we),
        .rdata    (csr_old)
    );

    mem_wb_regs u_mem_wb (
        .clk        (clk),
        .rst_n      (rst_n),
        .interlock  (interlock),
        .ir_type    (ir_type),
        .load_data  (load_data),
        .csr_data   (csr_old),
        .pc4        (pc4),
        .alu_result (z),
        .rd         (rd),
        .we_next    (wb_we_next),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data),
        .wb_we      (wb_we)
    );

endmodule

// ==== rtl/mem_wb_regs.sv ====
`timescale 1ns/10ps

module mem_wb_regs
    import pipe_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      interlock,
    input  ir_type_t  ir_type,
    input  word_t     load_data,
    input  word_t     csr_data,
    input  word_t     pc4,
    input  word_t     alu_result,
    input  reg_addr_t rd,
    input  logic      we_next,
    output reg_addr_t wb_rd,
    output word_t     wb_data,
    output logic      wb_we
);

    word_t wb_sel;

    always_comb begin
        case (ir_type)
            IR_LOAD: wb_sel = load_data;
            IR_CSR:  wb_sel = csr_data;
            IR_JUMP: wb_sel = pc4;
            default: wb_sel = alu_result;
        endcase
    end

    // bubble while the access is pending, so a load writes back once
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            wb_we <= 1'b0;
        else
            wb_we <= we_next && !interlock;
    end

    always_ff @(posedge clk) begin
        wb_rd   <= rd;
        wb_data <= wb_sel;
    end

endmodule

// ==== rtl/csr_file.sv ====
`timescale 1ns/10ps
`include "pipeline_consts.svh"

module csr_file
    import pipe_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  csr_addr_t csr_addr,
    input  word_t     wdata,
    input  logic      we,
    output word_t     rdata
);

    word_t      csr_q [4];
    logic       hit;
    logic [1:0] idx;

    always_comb begin
        hit = 1'b1;
        idx = 2'd0;
        case (csr_addr)
            `CSR_MSCRATCH: idx = 2'd0;
            `CSR_MTVEC:    idx = 2'd1;
            `CSR_MEPC:     idx = 2'd2;
            `CSR_MCAUSE:   idx = 2'd3;
            default:       hit = 1'b0;
        endcase
    end

    // old value goes to writeback, new value lands at the edge
    assign rdata = hit ? csr_q[idx] : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 4; i++)
                csr_q[i] <= '0;
        end else if (we && hit) begin
            csr_q[idx] <= wdata;
        end
    end

endmodule

// ==== mem_stage/data_ram.sv ====
`timescale 1ns/10ps
`include "pipeline_consts.svh"

module data_ram
    import pipe_pkg::*;
    import mem_pkg::*;
(
    input  logic       clk,
    input  logic [5:0] addr,
    input  logic       we,
    input  byte_en_t   byte_en,
    input  word_t      wdata,
    output word_t      rdata
);

    word_t mem [`DMEM_WORDS] = '{default: '0};

    always_ff @(posedge clk) begin
        if (we) begin
            for (int i = 0; i < 4; i++) begin
                if (byte_en[i])
                    mem[addr][8*i +: 8] <= wdata[8*i +: 8];
            end
        end
        // read returns the word as it was before a same-cycle write
        rdata <= mem[addr];
    end

endmodule

// ==== mem_stage/lsu_align.sv ====
`timescale 1ns/10ps

module lsu_align
    import pipe_pkg::*;
    import mem_pkg::*;
(
    input  logic [1:0] addr_lo,
    input  funct3_t    funct3,
    input  word_t      store_data,
    input  word_t      ram_rdata,
    output byte_en_t   byte_en,
    output word_t      ram_wdata,
    output word_t      load_data
);

    logic [7:0]  load_byte;
    logic [15:0] load_half;

    // store side, data is replicated so only the enables pick the lane
    always_comb begin
        case (funct3[1:0])
            2'b00: begin
                ram_wdata = {4{store_data[7:0]}};
                byte_en   = byte_en_t'(4'b0001 << addr_lo);
            end
            2'b01: begin
                ram_wdata = {2{store_data[15:0]}};
                byte_en   = addr_lo[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                ram_wdata = store_data;
                byte_en   = 4'b1111;
            end
        endcase
    end

    assign load_byte = ram_rdata[8*addr_lo +: 8];
    assign load_half = addr_lo[1] ? ram_rdata[31:16] : ram_rdata[15:0];

    // funct3[2] selects zero extension
    always_comb begin
        case (funct3[1:0])
            2'b00:   load_data = {{24{load_byte[7] & ~funct3[2]}}, load_byte};
            2'b01:   load_data = {{16{load_half[15] & ~funct3[2]}}, load_half};
            default: load_data = ram_rdata;
        endcase
    end

endmodule

// ==== mem_stage/mem_stage_ctrl.sv ====
`timescale 1ns/10ps
`include "pipeline_consts.svh"

module mem_stage_ctrl
    import pipe_pkg::*;
    import mem_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  ir_type_t  ir_type,
    input  logic      flush,
    input  logic      wr_reg_n,
    input  logic      wr_csr_n,
    input  reg_addr_t rd,
    output logic      interlock,
    output logic      ram_we,
    output logic      csr_we,
    output logic      wb_we_next
);

    localparam int CNT_W = $clog2(`MEM_WAIT_CYCLES + 1);

    mem_state_t       state;
    mem_state_t       state_next;
    logic [CNT_W-1:0] wait_cnt;
    logic             is_mem;

    assign is_mem = (ir_type == IR_LOAD) || (ir_type == IR_STORE);

    always_comb begin
        state_next = state;
        case (state)
            MS_IDLE: if (is_mem) state_next = MS_WAIT;
            MS_WAIT: if (wait_cnt == CNT_W'(`MEM_WAIT_CYCLES - 1)) state_next = MS_DONE;
            default: state_next = MS_IDLE;
        endcase
    end

    // the entry cycle already counts as the first wait cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= MS_IDLE;
            wait_cnt <= '0;
        end else begin
            state <= state_next;
            if (state == MS_IDLE)
                wait_cnt <= CNT_W'(1);
            else if (state == MS_WAIT)
                wait_cnt <= wait_cnt + 1'b1;
        end
    end

    assign interlock = (state == MS_WAIT) || ((state == MS_IDLE) && is_mem);

    // store lands once, when the access completes
    assign ram_we = (state == MS_DONE) && (ir_type == IR_STORE) && !flush;

    assign csr_we = (ir_type == IR_CSR) && !wr_csr_n && !flush;

    // loads are held back by interlock in mem_wb until MS_DONE
    assign wb_we_next = !flush && !wr_reg_n && (rd != '0) &&
                        ((ir_type == IR_ALU) || (ir_type == IR_LOAD) ||
                         (ir_type == IR_CSR) || (ir_type == IR_JUMP));

endmodule

// ==== rtl/ex_mem_regs.sv ====
`timescale 1ns/10ps
`include "pipeline_consts.svh"

module ex_mem_regs
    import pipe_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      interlock,
    input  word_t     pc4_in,
    input  word_t     b_in,
    input  word_t     c_in,
    input  word_t     z_in,
    input  funct3_t   funct3_in,
    input  reg_addr_t rd_in,
    input  csr_addr_t csr_addr_in,
    input  ir_type_t  ir_type_in,
    input  logic      wr_reg_n_in,
    input  logic      wr_csr_n_in,
    input  logic      flush_in,
    output word_t     pc4_out,
    output word_t     b_out,
    output word_t     c_out,
    output word_t     z_out,
    output funct3_t   funct3_out,
    output reg_addr_t rd_out,
    output csr_addr_t csr_addr_out,
    output ir_type_t  ir_type_out,
    output logic      wr_reg_n_out,
    output logic      wr_csr_n_out,
    output logic      flush_out
);

    // interlock freezes the instruction while the memory access is pending
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc4_out      <= `DEFAULT_PC4;
            b_out        <= `DEFAULT_B;
            c_out        <= `DEFAULT_C;
            z_out        <= `DEFAULT_Z;
            funct3_out   <= `DEFAULT_FUNCT3;
            rd_out       <= `DEFAULT_REG;
            csr_addr_out <= `DEFAULT_CSR_ADDR;
            ir_type_out  <= ir_type_t'(`DEFAULT_IR_TYPE);
            wr_reg_n_out <= `DEFAULT_WR_N;
            wr_csr_n_out <= `DEFAULT_WR_N;
            flush_out    <= `DEFAULT_FLUSH;
        end else if (!interlock) begin
            pc4_out      <= pc4_in;
            b_out        <= b_in;
            c_out        <= c_in;
            z_out        <= z_in;
            funct3_out   <= funct3_in;
            rd_out       <= rd_in;
            csr_addr_out <= csr_addr_in;
            ir_type_out  <= ir_type_in;
            wr_reg_n_out <= wr_reg_n_in;
            wr_csr_n_out <= wr_csr_n_in;
            flush_out    <= flush_in;
        end
    end

endmodule

// ==== common/mem_pkg.sv ====
package mem_pkg;

    typedef enum logic [1:0] {
        MS_IDLE = 2'd0,
        MS_WAIT = 2'd1,
        MS_DONE = 2'd2
    } mem_state_t;

    // one enable per byte lane of the data word
    typedef logic [3:0] byte_en_t;

endpackage

// ==== common/pipe_pkg.sv ====
package pipe_pkg;

    // data word, also used for addresses and the link value
    typedef logic [31:0] word_t;

    typedef logic [4:0]  reg_addr_t;
    typedef logic [11:0] csr_addr_t;

    // size in bits [1:0], unsigned load in bit 2
    typedef logic [2:0]  funct3_t;

    // instruction class carried down the pipe, nop is the reset value
    typedef enum logic [3:0] {
        IR_NOP   = 4'd0,
        IR_ALU   = 4'd1,
        IR_LOAD  = 4'd2,
        IR_STORE = 4'd3,
        IR_CSR   = 4'd4,
        IR_JUMP  = 4'd5
    } ir_type_t;

endpackage

// ==== common/pipeline_consts.svh ====
`ifndef PIPELINE_CONSTS_SVH
`define PIPELINE_CONSTS_SVH

// ex/mem register reset values
`define DEFAULT_PC4      32'h0000_0000
`define DEFAULT_B        32'h0000_0000
`define DEFAULT_C        32'h0000_0000
`define DEFAULT_Z        32'h0000_0000
`define DEFAULT_FUNCT3   3'b000
`define DEFAULT_REG      5'd0
`define DEFAULT_CSR_ADDR 12'h000
`define DEFAULT_IR_TYPE  4'd0
`define DEFAULT_WR_N     1'b1
`define DEFAULT_FLUSH    1'b0

// data ram is addressed with z[7:2]
`define DMEM_WORDS       64
`define MEM_WAIT_CYCLES  2

`define CSR_MSCRATCH     12'h340
`define CSR_MTVEC        12'h305
`define CSR_MEPC         12'h341
`define CSR_MCAUSE       12'h342

`endif
